// ==== hdl/csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// data path width
`define CSR_XLEN 32

// width of a csr address field
`define CSR_ADDR_W 12

// machine-mode csr addresses
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342

// read-only identity registers
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12

// mstatus bit positions
`define CSR_MSTATUS_MIE  3
`define CSR_MSTATUS_MPIE 7

// identity words returned on read
`define CSR_MVENDORID_VAL 32'h7973_7978
`define CSR_MARCHID_VAL   32'h015f_de77

// mcause code for an environment call from M-mode
`define CSR_CAUSE_ECALL_M 11

`endif

// ==== hdl/csr_pkg.sv ====
`include "csr_params.svh"

package csr_pkg;

  // one machine word
  typedef logic [`CSR_XLEN-1:0] xlen_t;

  // csr address as encoded in the instruction
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  // command kind from the execute stage
  typedef enum logic [2:0] {
    CSR_OP_NONE  = 3'd0,
    CSR_OP_RW    = 3'd1,
    CSR_OP_RS    = 3'd2,
    CSR_OP_RC    = 3'd3,
    CSR_OP_ECALL = 3'd4,
    CSR_OP_MRET  = 3'd5
  } csr_op_e;

  // storage slot of a writable csr
  // IDX_NONE means the write is dropped
  typedef enum logic [2:0] {
    IDX_NONE    = 3'd0,
    IDX_MCAUSE  = 3'd1,
    IDX_MEPC    = 3'd2,
    IDX_MTVEC   = 3'd3,
    IDX_MSTATUS = 3'd4
  } csr_idx_e;

endpackage

// ==== hdl/csr_regfile.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_regfile (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid,
  input  logic               wen,
  input  logic               ecall,
  input  logic               mret,
  input  csr_pkg::csr_addr_t waddr,
  input  csr_pkg::csr_addr_t waddr_add1,
  input  csr_pkg::xlen_t     wdata,
  input  csr_pkg::xlen_t     wdata_add1,
  input  csr_pkg::csr_addr_t raddr,
  output csr_pkg::xlen_t     rdata,
  output csr_pkg::xlen_t     mtvec,
  output csr_pkg::xlen_t     mepc
);
  import csr_pkg::*;

  xlen_t    mstatus_q;
  xlen_t    mcause_q;
  xlen_t    mepc_q;
  xlen_t    mtvec_q;
  xlen_t    mstatus_d;
  xlen_t    mcause_d;
  xlen_t    mepc_d;
  xlen_t    mtvec_d;
  csr_idx_e widx_1;
  csr_idx_e widx_2;
  logic     wr_en;

  function automatic csr_idx_e addr_to_idx(input csr_addr_t a);
    csr_idx_e idx;
    case (a)
      `CSR_ADDR_MCAUSE:  idx = IDX_MCAUSE;
      `CSR_ADDR_MEPC:    idx = IDX_MEPC;
      `CSR_ADDR_MTVEC:   idx = IDX_MTVEC;
      `CSR_ADDR_MSTATUS: idx = IDX_MSTATUS;
      default:           idx = IDX_NONE;
    endcase
    return idx;
  endfunction

  // new value of one slot after both write ports
  // port 2 is applied last and wins on a shared slot
  function automatic xlen_t port_write(
    input csr_idx_e slot,
    input xlen_t    cur
  );
    xlen_t val;
    val = cur;
    if (widx_1 == slot) val = wdata;
    if (widx_2 == slot) val = wdata_add1;
    return val;
  endfunction

  assign widx_1 = addr_to_idx(waddr);
  assign widx_2 = addr_to_idx(waddr_add1);
  assign wr_en  = valid & wen;

  always_comb begin
    mstatus_d = mstatus_q;
    mcause_d  = mcause_q;
    mepc_d    = mepc_q;
    mtvec_d   = mtvec_q;
    if (wr_en) begin
      mstatus_d = port_write(IDX_MSTATUS, mstatus_q);
      mcause_d  = port_write(IDX_MCAUSE, mcause_q);
      mepc_d    = port_write(IDX_MEPC, mepc_q);
      mtvec_d   = port_write(IDX_MTVEC, mtvec_q);
    end
    // trap entry stacks the interrupt enable
    if (valid && ecall) begin
      mstatus_d[`CSR_MSTATUS_MPIE] = mstatus_q[`CSR_MSTATUS_MIE];
      mstatus_d[`CSR_MSTATUS_MIE]  = 1'b0;
    end
    // trap return pops it again
    if (valid && mret) begin
      mstatus_d[`CSR_MSTATUS_MIE]  = mstatus_q[`CSR_MSTATUS_MPIE];
      mstatus_d[`CSR_MSTATUS_MPIE] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mcause_q  <= '0;
      mepc_q    <= '0;
      mtvec_q   <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mcause_q  <= mcause_d;
      mepc_q    <= mepc_d;
      mtvec_q   <= mtvec_d;
    end
  end

  // read port, old value of raddr
  always_comb begin
    case (raddr)
      `CSR_ADDR_MSTATUS:   rdata = mstatus_q;
      `CSR_ADDR_MCAUSE:    rdata = mcause_q;
      `CSR_ADDR_MEPC:      rdata = mepc_q;
      `CSR_ADDR_MTVEC:     rdata = mtvec_q;
      `CSR_ADDR_MVENDORID: rdata = `CSR_MVENDORID_VAL;
      `CSR_ADDR_MARCHID:   rdata = `CSR_MARCHID_VAL;
      default:             rdata = '0;
    endcase
  end

  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

endmodule

// ==== hdl/csr_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_cmd_ctrl (
  input  logic               valid,
  input  csr_pkg::csr_op_e   op,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     src,
  input  csr_pkg::xlen_t     pc,
  input  csr_pkg::xlen_t     old,
  input  csr_pkg::xlen_t     mtvec,
  input  csr_pkg::xlen_t     mepc,
  output logic               wen,
  output logic               ecall,
  output logic               mret,
  output csr_pkg::csr_addr_t waddr,
  output csr_pkg::csr_addr_t waddr_add1,
  output csr_pkg::xlen_t     wdata,
  output csr_pkg::xlen_t     wdata_add1,
  output logic               redirect,
  output csr_pkg::xlen_t     redirect_pc
);
  import csr_pkg::*;

  // an address outside the writable set, so port 2 is a no-op
  localparam csr_addr_t ADDR_NONE = '0;

  xlen_t rmw_val;
  xlen_t trap_vec;
  logic  redirect_req;

  // direct mode only, low two mode bits dropped
  assign trap_vec = {mtvec[`CSR_XLEN-1:2], 2'b00};

  // read-modify-write value
  always_comb begin
    case (op)
      CSR_OP_RS: rmw_val = old | src;
      CSR_OP_RC: rmw_val = old & ~src;
      default:   rmw_val = src;
    endcase
  end

  always_comb begin
    wen          = 1'b0;
    ecall        = 1'b0;
    mret         = 1'b0;
    waddr        = ADDR_NONE;
    waddr_add1   = ADDR_NONE;
    wdata        = '0;
    wdata_add1   = '0;
    redirect_req = 1'b0;
    redirect_pc  = '0;
    case (op)
      CSR_OP_RW, CSR_OP_RS, CSR_OP_RC: begin
        wen   = 1'b1;
        waddr = addr;
        wdata = rmw_val;
      end
      CSR_OP_ECALL: begin
        wen          = 1'b1;
        ecall        = 1'b1;
        waddr        = `CSR_ADDR_MEPC;
        wdata        = pc;
        waddr_add1   = `CSR_ADDR_MCAUSE;
        wdata_add1   = xlen_t'(`CSR_CAUSE_ECALL_M);
        redirect_req = 1'b1;
        redirect_pc  = trap_vec;
      end
      CSR_OP_MRET: begin
        mret         = 1'b1;
        redirect_req = 1'b1;
        redirect_pc  = mepc;
      end
      default: begin
      end
    endcase
  end

  // writes are qualified by valid in the regfile
  assign redirect = valid & redirect_req;

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid,
  input  csr_pkg::csr_op_e   op,
  input  csr_pkg::csr_addr_t addr,
  input  csr_pkg::xlen_t     src,
  input  csr_pkg::xlen_t     pc,
  output csr_pkg::xlen_t     rdata,
  output csr_pkg::xlen_t     redirect_pc,
  output logic               redirect
);
  import csr_pkg::*;

  // controller to regfile write ports
  logic      wen;
  logic      ecall;
  logic      mret;
  csr_addr_t waddr;
  csr_addr_t waddr_add1;
  xlen_t     wdata;
  xlen_t     wdata_add1;

  // trap targets back from the regfile
  xlen_t     mtvec;
  xlen_t     mepc;

  csr_cmd_ctrl u_ctrl (
    .valid       (valid),
    .op          (op),
    .addr        (addr),
    .src         (src),
    .pc          (pc),
    .old         (rdata),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .wen         (wen),
    .ecall       (ecall),
    .mret        (mret),
    .waddr       (waddr),
    .waddr_add1  (waddr_add1),
    .wdata       (wdata),
    .wdata_add1  (wdata_add1),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  // read address is the command address
  csr_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .valid      (valid),
    .wen        (wen),
    .ecall      (ecall),
    .mret       (mret),
    .waddr      (waddr),
    .waddr_add1 (waddr_add1),
    .wdata      (wdata),
    .wdata_add1 (wdata_add1),
    .raddr      (addr),
    .rdata      (rdata),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

endmodule

// ==== tb/csr_tb.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb;
  import csr_pkg::*;

  localparam int RAND_CYCLES = 3000;
  localparam int MAX_CYCLES  = 10000;
  localparam int IDLE_WAIT   = 10;

  logic      clk;
  logic      rst;
  logic      valid;
  csr_op_e   op;
  csr_addr_t addr;
  xlen_t     src;
  xlen_t     pc;
  xlen_t     rdata;
  xlen_t     redirect_pc;
  logic      redirect;

  // reference copies of the writable csrs
  xlen_t m_mstatus;
  xlen_t m_mcause;
  xlen_t m_mepc;
  xlen_t m_mtvec;

  int n_err;
  int n_chk;

  csr_unit dut (
    .clk         (clk),
    .rst         (rst),
    .valid       (valid),
    .op          (op),
    .addr        (addr),
    .src         (src),
    .pc          (pc),
    .rdata       (rdata),
    .redirect_pc (redirect_pc),
    .redirect    (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // stuck-run guard
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  function automatic xlen_t model_read(input csr_addr_t a);
    case (a)
      `CSR_ADDR_MSTATUS:   return m_mstatus;
      `CSR_ADDR_MCAUSE:    return m_mcause;
      `CSR_ADDR_MEPC:      return m_mepc;
      `CSR_ADDR_MTVEC:     return m_mtvec;
      `CSR_ADDR_MVENDORID: return `CSR_MVENDORID_VAL;
      `CSR_ADDR_MARCHID:   return `CSR_MARCHID_VAL;
      default:             return '0;
    endcase
  endfunction

  // read-only and unknown addresses drop the write
  task automatic model_write(input csr_addr_t a, input xlen_t val);
    case (a)
      `CSR_ADDR_MSTATUS: m_mstatus = val;
      `CSR_ADDR_MCAUSE:  m_mcause  = val;
      `CSR_ADDR_MEPC:    m_mepc    = val;
      `CSR_ADDR_MTVEC:   m_mtvec   = val;
      default: begin
      end
    endcase
  endtask

  // state change at an edge where valid is high
  task automatic model_step(input csr_op_e o, input csr_addr_t a, input xlen_t s,
                            input xlen_t p);
    xlen_t old;
    logic  mie;
    old = model_read(a);
    mie = m_mstatus[`CSR_MSTATUS_MIE];
    case (o)
      CSR_OP_RW: model_write(a, s);
      CSR_OP_RS: model_write(a, old | s);
      CSR_OP_RC: model_write(a, old & ~s);
      CSR_OP_ECALL: begin
        m_mepc   = p;
        m_mcause = xlen_t'(`CSR_CAUSE_ECALL_M);
        m_mstatus[`CSR_MSTATUS_MPIE] = mie;
        m_mstatus[`CSR_MSTATUS_MIE]  = 1'b0;
      end
      CSR_OP_MRET: begin
        m_mstatus[`CSR_MSTATUS_MIE]  = m_mstatus[`CSR_MSTATUS_MPIE];
        m_mstatus[`CSR_MSTATUS_MPIE] = 1'b1;
      end
      default: begin
      end
    endcase
  endtask

  // one command cycle with outputs sampled 2 ns before the next edge
  task automatic run_cycle(input logic v, input csr_op_e o, input csr_addr_t a,
                           input xlen_t s, input xlen_t p);
    logic trap;
    @(posedge clk);
    #2;
    valid = v;
    op    = o;
    addr  = a;
    src   = s;
    pc    = p;
    #16;
    trap = (o == CSR_OP_ECALL) || (o == CSR_OP_MRET);
    check_bit(redirect, v && trap, "redirect");
    if (v && o == CSR_OP_ECALL)
      check_word(redirect_pc, m_mtvec & ~xlen_t'(3), "redirect_pc on ecall");
    if (v && o == CSR_OP_MRET)
      check_word(redirect_pc, m_mepc, "redirect_pc on mret");
    if (v)
      check_word(rdata, model_read(a), "rdata");
    if (v)
      model_step(o, a, s, p);
  endtask

  task automatic read_csr(input csr_addr_t a);
    run_cycle(1'b1, CSR_OP_NONE, a, '0, '0);
  endtask

  function automatic csr_op_e pick_op(input logic [31:0] r);
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3:   return CSR_OP_RW;
      4'd4, 4'd5, 4'd6, 4'd7:   return CSR_OP_RS;
      4'd8, 4'd9, 4'd10, 4'd11: return CSR_OP_RC;
      4'd12, 4'd13:             return CSR_OP_ECALL;
      4'd14:                    return CSR_OP_MRET;
      default:                  return CSR_OP_NONE;
    endcase
  endfunction

  // mostly the six known csrs and now and then a stray address
  function automatic csr_addr_t pick_addr(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return `CSR_ADDR_MSTATUS;
      3'd1:    return `CSR_ADDR_MCAUSE;
      3'd2:    return `CSR_ADDR_MEPC;
      3'd3:    return `CSR_ADDR_MTVEC;
      3'd4:    return `CSR_ADDR_MVENDORID;
      3'd5:    return `CSR_ADDR_MARCHID;
      3'd6:    return r[19:8];
      default: return `CSR_ADDR_MSTATUS;
    endcase
  endfunction

  // redirect must settle low once reset is gone
  task automatic wait_idle();
    int n;
    n = 0;
    while (redirect !== 1'b0 && n < IDLE_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (redirect !== 1'b0) begin
      n_err++;
      $display("redirect stayed high %0d cycles after reset", IDLE_WAIT);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic        v;
    valid     = 1'b0;
    op        = CSR_OP_NONE;
    addr      = '0;
    src       = '0;
    pc        = '0;
    rst       = 1'b1;
    m_mstatus = '0;
    m_mcause  = '0;
    m_mepc    = '0;
    m_mtvec   = '0;
    n_err     = 0;
    n_chk     = 0;
    void'($urandom(32'h7ae612b8));

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    wait_idle();

    // reset values and identity words
    read_csr(`CSR_ADDR_MSTATUS);
    read_csr(`CSR_ADDR_MCAUSE);
    read_csr(`CSR_ADDR_MEPC);
    read_csr(`CSR_ADDR_MTVEC);
    read_csr(`CSR_ADDR_MVENDORID);
    read_csr(`CSR_ADDR_MARCHID);
    read_csr(12'h123);

    // read-modify-write rules
    run_cycle(1'b1, CSR_OP_RW, `CSR_ADDR_MTVEC, 32'h8000_0103, '0);
    read_csr(`CSR_ADDR_MTVEC);
    run_cycle(1'b1, CSR_OP_RS, `CSR_ADDR_MSTATUS, 32'h0000_0088, '0);
    run_cycle(1'b1, CSR_OP_RC, `CSR_ADDR_MSTATUS, 32'h0000_0080, '0);
    read_csr(`CSR_ADDR_MSTATUS);
    run_cycle(1'b1, CSR_OP_RW, `CSR_ADDR_MVENDORID, 32'hdead_beef, '0);
    run_cycle(1'b1, CSR_OP_RW, 12'h7c0, 32'h1234_5678, '0);
    read_csr(`CSR_ADDR_MVENDORID);
    read_csr(12'h7c0);

    // trap entry, then trap return
    run_cycle(1'b1, CSR_OP_ECALL, `CSR_ADDR_MSTATUS, '0, 32'h0000_1234);
    read_csr(`CSR_ADDR_MEPC);
    read_csr(`CSR_ADDR_MCAUSE);
    read_csr(`CSR_ADDR_MSTATUS);
    run_cycle(1'b1, CSR_OP_RW, `CSR_ADDR_MEPC, 32'h0000_2000, '0);
    run_cycle(1'b1, CSR_OP_MRET, `CSR_ADDR_MSTATUS, '0, '0);
    read_csr(`CSR_ADDR_MSTATUS);
    run_cycle(1'b0, CSR_OP_ECALL, `CSR_ADDR_MEPC, '0, 32'h0000_4000);

    for (int i = 0; i < RAND_CYCLES; i++) begin
      r = $urandom();
      v = (r[1:0] != 2'b00);
      run_cycle(v, pick_op($urandom()), pick_addr($urandom()), $urandom(),
                $urandom() & 32'hffff_fffc);
    end

    $display("checks: %0d  errors: %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_regfile.sv
hdl/csr_cmd_ctrl.sv
hdl/csr_unit.sv
tb/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module csr_tb \
  -f flist.f -o csr_sim > build.log 2>&1 &&
./obj_dir/csr_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TEST PASSED" sim.log &&
{ echo "simulation passed"; exit 0; } ||
{ echo "simulation failed, see sim.log"; exit 1; }
